// File: rng_defines.svh
// Width, seed, FIFO depth and register offset macros for the RNG peripheral, included by RTL and testbench
`ifndef RNG_DEFINES_SVH
`define RNG_DEFINES_SVH

// Generator word
`define RNG_WIDTH           20

// Reset state, also used in place of a zero seed
`define RNG_SEED_DEFAULT    20'hFACEB

// Output FIFO depth, power of two
`define RNG_FIFO_DEPTH      8

// Wishbone bus widths
`define WB_DATA_WIDTH       32
`define WB_ADDR_WIDTH       4

// Register byte offsets, adr[3:2] selects the register
`define RNG_REG_CTRL        4'h0
`define RNG_REG_SEED        4'h4
`define RNG_REG_DATA        4'h8
`define RNG_REG_STATUS      4'hC

`endif

// File: rng_pkg.sv
// Shared types of the RNG peripheral, imported by the RTL modules and the testbench
`include "rng_defines.svh"

package rng_pkg;

    // One LFSR state or one generated word
    typedef logic [`RNG_WIDTH-1:0] rng_word_t;

    // Wishbone data and byte address
    typedef logic [`WB_DATA_WIDTH-1:0] wb_data_t;
    typedef logic [`WB_ADDR_WIDTH-1:0] wb_addr_t;

    // Occupancy from 0 up to and including the FIFO depth
    typedef logic [$clog2(`RNG_FIFO_DEPTH + 1)-1:0] fifo_count_t;

endpackage

// File: rng_lfsr_core.sv
// 20-bit LFSR generator advancing four bits per step, pushes every new state into the output FIFO
`timescale 1ns/100ps
`include "rng_defines.svh"

module rng_lfsr_core (
    input  logic               clk,
    input  logic               rst,
    input  logic               enable,
    input  logic               seed_load,
    input  rng_pkg::rng_word_t seed_value,
    input  logic               full,
    output logic               push,
    output rng_pkg::rng_word_t push_data,
    output rng_pkg::rng_word_t state
);
    import rng_pkg::*;

    rng_word_t  state_q;
    rng_word_t  step_word;
    rng_word_t  load_word;
    logic [3:0] taps;
    logic       step_en;

    // Four feedback bits, t0 lands in bit 0 of the new state
    always_comb begin
        taps[0] = state_q[19] ^ state_q[16];
        taps[1] = state_q[15] ^ state_q[12];
        taps[2] = state_q[11] ^ state_q[8];
        taps[3] = state_q[7] ^ state_q[0];
    end

    // Shift left by four and append t3..t0
    assign step_word = {state_q[15:0], taps[3], taps[2], taps[1], taps[0]};

    // All-zero state would lock up
    assign load_word = (seed_value == '0) ? `RNG_SEED_DEFAULT : seed_value;

    // Seed load wins over stepping, a full FIFO stalls the generator
    assign step_en = enable && !full && !seed_load;

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= `RNG_SEED_DEFAULT;
        end else if (seed_load) begin
            state_q <= load_word;
        end else if (step_en) begin
            state_q <= step_word;
        end
    end

    // FIFO captures the new state at the same edge the state register takes it
    assign push      = step_en;
    assign push_data = step_word;

    // Readback for the SEED register
    assign state = state_q;

endmodule

// File: rng_fifo.sv
// Synchronous FIFO of generator words between the LFSR core and the register block
`timescale 1ns/100ps
`include "rng_defines.svh"

module rng_fifo #(
    parameter int DEPTH = `RNG_FIFO_DEPTH
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 push,
    input  rng_pkg::rng_word_t   push_data,
    input  logic                 pop,
    output rng_pkg::rng_word_t   rd_data,
    output rng_pkg::fifo_count_t count,
    output logic                 empty,
    output logic                 full
);
    import rng_pkg::*;

    localparam int PTR_W = $clog2(DEPTH);

    rng_word_t        mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    fifo_count_t      count_q;
    logic             do_push;
    logic             do_pop;

    // Pop on empty is dropped here, the register block flags it
    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    // Storage
    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    // Pointers wrap on their own for power-of-two depths
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // Occupancy, unchanged when push and pop coincide
    always_ff @(posedge clk) begin
        if (rst) begin
            count_q <= '0;
        end else begin
            case ({do_push, do_pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    // Head entry is visible without a read cycle
    assign rd_data = mem[rd_ptr];

    assign count = count_q;
    assign empty = (count_q == '0);
    assign full  = (count_q == fifo_count_t'(DEPTH));

endmodule

// File: rng_wb_regs.sv
// Wishbone classic slave with the CTRL, SEED, DATA and STATUS registers of the RNG peripheral
`timescale 1ns/100ps
`include "rng_defines.svh"

module rng_wb_regs (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 cyc,
    input  logic                 stb,
    input  logic                 we,
    input  rng_pkg::wb_addr_t    adr,
    input  rng_pkg::wb_data_t    dat_i,
    output rng_pkg::wb_data_t    dat_o,
    output logic                 ack,
    output logic                 enable,
    output logic                 seed_load,
    output rng_pkg::rng_word_t   seed_value,
    input  rng_pkg::rng_word_t   state,
    output logic                 pop,
    input  rng_pkg::rng_word_t   rd_data,
    input  rng_pkg::fifo_count_t count,
    input  logic                 empty,
    input  logic                 full
);
    import rng_pkg::*;

    localparam int PAD_W = `WB_DATA_WIDTH - `RNG_WIDTH;

    wb_addr_t reg_addr;
    logic     req;
    logic     wr_req;
    logic     rd_req;
    logic     data_rd;
    logic     underflow;
    wb_data_t status_word;
    wb_data_t rd_word;

    // No new request is taken while ack is still high
    assign req    = cyc && stb && !ack;
    assign wr_req = req && we;
    assign rd_req = req && !we;

    // Byte lanes are ignored, only the word index counts
    assign reg_addr = {adr[3:2], 2'b00};

    assign data_rd = rd_req && (reg_addr == `RNG_REG_DATA);

    // Strobes to the core and FIFO act at the same edge as ack rises
    assign seed_load  = wr_req && (reg_addr == `RNG_REG_SEED);
    assign seed_value = dat_i[`RNG_WIDTH-1:0];
    assign pop        = data_rd && !empty;

    always_comb begin
        status_word = '0;
        status_word[0] = empty;
        status_word[1] = full;
        status_word[2] = underflow;
        status_word[8 +: $bits(fifo_count_t)] = count;
    end

    // Read mux
    always_comb begin
        case (reg_addr)
            `RNG_REG_CTRL: begin
                rd_word = '0;
                rd_word[0] = enable;
            end
            `RNG_REG_SEED: begin
                rd_word = {{PAD_W{1'b0}}, state};
            end
            `RNG_REG_DATA: begin
                // Empty FIFO reads as zero
                rd_word = empty ? '0 : {{PAD_W{1'b0}}, rd_data};
            end
            default: begin
                rd_word = status_word;
            end
        endcase
    end

    // Control state and handshake
    always_ff @(posedge clk) begin
        if (rst) begin
            ack       <= 1'b0;
            enable    <= 1'b0;
            underflow <= 1'b0;
        end else begin
            ack <= req;
            if (wr_req) begin
                case (reg_addr)
                    `RNG_REG_CTRL: begin
                        enable <= dat_i[0];
                    end
                    `RNG_REG_STATUS: begin
                        // Write one to clear
                        if (dat_i[2]) begin
                            underflow <= 1'b0;
                        end
                    end
                    default: begin
                    end
                endcase
            end
            if (data_rd && empty) begin
                underflow <= 1'b1;
            end
        end
    end

    // Read data goes out together with ack
    always_ff @(posedge clk) begin
        if (req) begin
            dat_o <= we ? '0 : rd_word;
        end
    end

endmodule

// File: rng_top.sv
// Top level of the RNG peripheral, Wishbone register block in front of the LFSR core and its FIFO
`timescale 1ns/100ps
`include "rng_defines.svh"

module rng_top (
    input  logic              clk,
    input  logic              rst,
    input  logic              cyc,
    input  logic              stb,
    input  logic              we,
    input  rng_pkg::wb_addr_t adr,
    input  rng_pkg::wb_data_t dat_i,
    output rng_pkg::wb_data_t dat_o,
    output logic              ack
);
    import rng_pkg::*;

    logic        enable;
    logic        seed_load;
    rng_word_t   seed_value;
    rng_word_t   state;
    logic        pop;
    rng_word_t   rd_data;
    fifo_count_t count;
    logic        empty;
    logic        full;
    logic        push;
    rng_word_t   push_data;

    rng_wb_regs u_regs (
        .clk        (clk),
        .rst        (rst),
        .cyc        (cyc),
        .stb        (stb),
        .we         (we),
        .adr        (adr),
        .dat_i      (dat_i),
        .dat_o      (dat_o),
        .ack        (ack),
        .enable     (enable),
        .seed_load  (seed_load),
        .seed_value (seed_value),
        .state      (state),
        .pop        (pop),
        .rd_data    (rd_data),
        .count      (count),
        .empty      (empty),
        .full       (full)
    );

    rng_lfsr_core u_core (
        .clk        (clk),
        .rst        (rst),
        .enable     (enable),
        .seed_load  (seed_load),
        .seed_value (seed_value),
        .full       (full),
        .push       (push),
        .push_data  (push_data),
        .state      (state)
    );

    rng_fifo #(
        .DEPTH (`RNG_FIFO_DEPTH)
    ) u_fifo (
        .clk        (clk),
        .rst        (rst),
        .push       (push),
        .push_data  (push_data),
        .pop        (pop),
        .rd_data    (rd_data),
        .count      (count),
        .empty      (empty),
        .full       (full)
    );

endmodule

// File: rng_assert.sv
// Concurrent checks on the Wishbone handshake and FIFO flags, bound into rng_top for simulation
`timescale 1ns/100ps

module rng_assert (
    input logic clk,
    input logic rst,
    input logic cyc,
    input logic stb,
    input logic ack,
    input logic full,
    input logic empty,
    input logic push
);

    int assert_fails = 0;

    // Ack is a single-cycle pulse
    ack_one_cycle: assert property (@(posedge clk) disable iff (rst) ack |=> !ack)
        else begin
            assert_fails++;
            $error("ack stayed high for more than one cycle");
        end

    // Ack answers a request seen at the previous edge
    ack_after_req: assert property (@(posedge clk) disable iff (rst) ack |-> $past(cyc && stb))
        else begin
            assert_fails++;
            $error("ack without a preceding request");
        end

    flags_exclusive: assert property (@(posedge clk) disable iff (rst) !(full && empty))
        else begin
            assert_fails++;
            $error("FIFO full and empty at the same time");
        end

    // Core must stall under back-pressure
    no_push_full: assert property (@(posedge clk) disable iff (rst) full |-> !push)
        else begin
            assert_fails++;
            $error("push while the FIFO is full");
        end

endmodule

bind rng_top rng_assert u_assert (
    .clk   (clk),
    .rst   (rst),
    .cyc   (cyc),
    .stb   (stb),
    .ack   (ack),
    .full  (full),
    .empty (empty),
    .push  (push)
);

// File: tb_rng.sv
// Self-checking testbench for rng_top, random Wishbone traffic from a fixed seed against an LFSR model
`timescale 1ns/100ps
`include "rng_defines.svh"

module tb_rng;
    import rng_pkg::*;

    localparam int XFER_CYC       = 4;
    localparam int ACK_WAIT       = 8;
    localparam int POLL_MAX       = 32;
    localparam int N_SEEDS        = 5;
    localparam int WORDS_PER_SEED = 12;
    localparam int MAX_GAP        = 15;
    localparam int IDLE_ROUNDS    = 4;
    localparam int MAX_IDLE       = 31;
    localparam int DRAIN_XFERS    = `RNG_FIFO_DEPTH + 2;

    // Worst-case cycles of each test
    localparam int T_RESET = 3 * XFER_CYC;
    localparam int T_DEF   = (POLL_MAX + 12) * XFER_CYC;
    localparam int T_SEEDS = N_SEEDS * ((DRAIN_XFERS + 3 + 2 * WORDS_PER_SEED) * XFER_CYC
                             + WORDS_PER_SEED * MAX_GAP);
    localparam int T_ZERO  = (DRAIN_XFERS + 10) * XFER_CYC;
    localparam int T_UNDER = (DRAIN_XFERS + 6) * XFER_CYC;
    localparam int T_HOLD  = (2 * DRAIN_XFERS + 4 + 2 * IDLE_ROUNDS) * XFER_CYC
                             + (IDLE_ROUNDS + 1) * MAX_IDLE;
    localparam int TIMEOUT_CYCLES = 2 * (T_RESET + T_DEF + T_SEEDS + T_ZERO + T_UNDER + T_HOLD)
                                    + 100;

    logic     clk;
    logic     rst;
    logic     cyc;
    logic     stb;
    logic     we;
    wb_addr_t adr;
    wb_data_t dat_i;
    wb_data_t dat_o;
    logic     ack;

    integer    seed_var;
    int        errors;
    int        checks;
    int        tests_run;
    int        tests_failed;
    int        err_at_start;
    int        cycle_cnt;
    string     cur_test;
    rng_word_t model_state;
    rng_word_t expect_q[$];

    rng_top DUT (
        .clk   (clk),
        .rst   (rst),
        .cyc   (cyc),
        .stb   (stb),
        .we    (we),
        .adr   (adr),
        .dat_i (dat_i),
        .dat_o (dat_o),
        .ack   (ack)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Four tap pairs appended below the shifted state, t0 in bit 0
    function automatic rng_word_t lfsr_step(input rng_word_t s);
        logic t0;
        logic t1;
        logic t2;
        logic t3;
        t0 = s[19] ^ s[16];
        t1 = s[15] ^ s[12];
        t2 = s[11] ^ s[8];
        t3 = s[7] ^ s[0];
        return {s[15:0], t3, t2, t1, t0};
    endfunction

    function automatic int rand_range(input int max_val);
        return $unsigned($random(seed_var)) % (max_val + 1);
    endfunction

    task automatic model_load(input rng_word_t s);
        model_state = (s == '0) ? `RNG_SEED_DEFAULT : s;
        expect_q.delete();
    endtask

    task automatic expected_word(output rng_word_t w);
        if (expect_q.size() == 0) begin
            model_state = lfsr_step(model_state);
            expect_q.push_back(model_state);
        end
        w = expect_q.pop_front();
    endtask

    task automatic check_word(input string what, input rng_word_t exp, input rng_word_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("MISMATCH %0s %0s: expected %05h, actual %05h", cur_test, what, exp, act);
        end
    endtask

    task automatic check_data(input string what, input wb_data_t exp, input wb_data_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("MISMATCH %0s %0s: expected %08h, actual %08h", cur_test, what, exp, act);
        end
    endtask

    // One Wishbone classic transfer, waits for ack then releases the bus
    task automatic bus_xfer(input logic w, input wb_addr_t a, input wb_data_t d,
                            output wb_data_t q);
        int waited;
        @(posedge clk);
        cyc   <= 1'b1;
        stb   <= 1'b1;
        we    <= w;
        adr   <= a;
        dat_i <= d;
        waited = 0;
        @(negedge clk);
        while (ack !== 1'b1 && waited < ACK_WAIT) begin
            @(negedge clk);
            waited++;
        end
        if (ack !== 1'b1) begin
            errors++;
            $display("%0s: no ack from the DUT for the access at offset %h", cur_test, a);
        end else if (waited != 1) begin
            errors++;
            $display("%0s: ack came %0d cycles after the request at offset %h instead of 1",
                     cur_test, waited, a);
        end
        q = dat_o;
        @(posedge clk);
        cyc <= 1'b0;
        stb <= 1'b0;
        we  <= 1'b0;
    endtask

    task automatic bus_write(input wb_addr_t a, input wb_data_t d);
        wb_data_t unused;
        bus_xfer(1'b1, a, d, unused);
    endtask

    task automatic bus_read(input wb_addr_t a, output wb_data_t q);
        bus_xfer(1'b0, a, '0, q);
    endtask

    task automatic idle(input int n);
        repeat (n) @(posedge clk);
    endtask

    task automatic pop_and_check();
        wb_data_t  d;
        rng_word_t w;
        bus_read(`RNG_REG_DATA, d);
        expected_word(w);
        check_word("DATA word", w, d[`RNG_WIDTH-1:0]);
    endtask

    // Empties the FIFO while the generator is off, every word still checked
    task automatic drain_fifo();
        wb_data_t st;
        int       n;
        bus_read(`RNG_REG_STATUS, st);
        n = st[11:8];
        repeat (n) pop_and_check();
        bus_read(`RNG_REG_STATUS, st);
        check_data("STATUS after drain", 32'h1, st);
    endtask

    task automatic status_sane();
        wb_data_t st;
        int       cnt;
        bus_read(`RNG_REG_STATUS, st);
        cnt = st[11:8];
        checks++;
        if (st[0] !== (cnt == 0) || st[1] !== (cnt == `RNG_FIFO_DEPTH)
                || cnt > `RNG_FIFO_DEPTH) begin
            errors++;
            $display("%0s: STATUS flags disagree with count %0d (%08h)", cur_test, cnt, st);
        end
    endtask

    task automatic start_test(input string name);
        cur_test     = name;
        err_at_start = errors;
        tests_run++;
    endtask

    task automatic finish_test();
        if (errors == err_at_start) begin
            $display("test %0s: pass", cur_test);
        end else begin
            tests_failed++;
            $display("test %0s: fail, %0d errors", cur_test, errors - err_at_start);
        end
    endtask

    task automatic test_reset();
        wb_data_t d;
        start_test("reset_state");
        bus_read(`RNG_REG_CTRL, d);
        check_data("CTRL", 32'h0, d);
        bus_read(`RNG_REG_STATUS, d);
        check_data("STATUS", 32'h1, d);
        bus_read(`RNG_REG_SEED, d);
        check_word("SEED", `RNG_SEED_DEFAULT, d[`RNG_WIDTH-1:0]);
        model_load(`RNG_SEED_DEFAULT);
        finish_test();
    endtask

    task automatic test_default_seq();
        wb_data_t d;
        int       polls;
        logic     full_seen;
        start_test("default_sequence");
        model_load(`RNG_SEED_DEFAULT);
        repeat (`RNG_FIFO_DEPTH) begin
            model_state = lfsr_step(model_state);
            expect_q.push_back(model_state);
        end
        bus_write(`RNG_REG_CTRL, 32'h1);
        polls     = 0;
        full_seen = 1'b0;
        while (!full_seen && polls < POLL_MAX) begin
            bus_read(`RNG_REG_STATUS, d);
            full_seen = d[1];
            polls++;
        end
        if (!full_seen) begin
            errors++;
            $display("%0s: FIFO did not report full after %0d polls", cur_test, polls);
        end
        bus_write(`RNG_REG_CTRL, 32'h0);
        repeat (`RNG_FIFO_DEPTH) pop_and_check();
        bus_read(`RNG_REG_STATUS, d);
        check_data("STATUS after reads", 32'h1, d);
        finish_test();
    endtask

    task automatic test_random_seeds();
        wb_data_t s;
        start_test("random_seeds");
        repeat (N_SEEDS) begin
            bus_write(`RNG_REG_CTRL, 32'h0);
            drain_fifo();
            s = $random(seed_var);
            if (s[`RNG_WIDTH-1:0] == '0) begin
                s[0] = 1'b1;
            end
            bus_write(`RNG_REG_SEED, s);
            model_load(s[`RNG_WIDTH-1:0]);
            bus_write(`RNG_REG_CTRL, 32'h1);
            repeat (WORDS_PER_SEED) begin
                pop_and_check();
                if (rand_range(3) == 0) begin
                    status_sane();
                end else begin
                    idle(rand_range(MAX_GAP));
                end
            end
        end
        finish_test();
    endtask

    task automatic test_zero_seed();
        wb_data_t d;
        start_test("zero_seed");
        bus_write(`RNG_REG_CTRL, 32'h0);
        drain_fifo();
        bus_write(`RNG_REG_SEED, 32'h0);
        bus_read(`RNG_REG_SEED, d);
        check_word("SEED after zero write", `RNG_SEED_DEFAULT, d[`RNG_WIDTH-1:0]);
        model_load('0);
        bus_write(`RNG_REG_CTRL, 32'h1);
        repeat (6) pop_and_check();
        bus_write(`RNG_REG_CTRL, 32'h0);
        finish_test();
    endtask

    task automatic test_underflow();
        wb_data_t d;
        start_test("underflow");
        drain_fifo();
        bus_read(`RNG_REG_DATA, d);
        check_data("DATA on empty", 32'h0, d);
        bus_read(`RNG_REG_STATUS, d);
        check_data("STATUS after underflow", 32'h5, d);
        bus_write(`RNG_REG_STATUS, 32'h4);
        bus_read(`RNG_REG_STATUS, d);
        check_data("STATUS after clear", 32'h1, d);
        finish_test();
    endtask

    task automatic test_hold();
        wb_data_t  st0;
        wb_data_t  sd0;
        wb_data_t  d;
        rng_word_t exp_state;
        start_test("hold_disabled");
        bus_write(`RNG_REG_CTRL, 32'h1);
        // Stop while the FIFO still has room so a missed disable moves the count
        idle(rand_range(`RNG_FIFO_DEPTH - 4));
        bus_write(`RNG_REG_CTRL, 32'h0);
        bus_read(`RNG_REG_STATUS, st0);
        bus_read(`RNG_REG_SEED, sd0);
        // The core sits on the newest word, count steps past the last one read
        exp_state = model_state;
        repeat (int'(st0[11:8])) exp_state = lfsr_step(exp_state);
        check_word("SEED when stopped", exp_state, sd0[`RNG_WIDTH-1:0]);
        repeat (IDLE_ROUNDS) begin
            idle(rand_range(MAX_IDLE));
            bus_read(`RNG_REG_STATUS, d);
            check_data("STATUS while idle", st0, d);
            bus_read(`RNG_REG_SEED, d);
            check_data("SEED while idle", sd0, d);
        end
        drain_fifo();
        finish_test();
    endtask

    // Watchdog
    initial begin
        cycle_cnt = 0;
        while (cycle_cnt <= TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("ERRORS FOUND");
        $finish;
    end

    initial begin
        cyc          = 1'b0;
        stb          = 1'b0;
        we           = 1'b0;
        adr          = '0;
        dat_i        = '0;
        rst          = 1'b1;
        errors       = 0;
        checks       = 0;
        tests_run    = 0;
        tests_failed = 0;
        cur_test     = "setup";
        seed_var     = 32'h7c16_f1d8;
        model_load(`RNG_SEED_DEFAULT);
        repeat (2) @(posedge clk);
        rst <= 1'b0;

        test_reset();
        test_default_seq();
        test_random_seeds();
        test_zero_seed();
        test_underflow();
        test_hold();

        if (DUT.u_assert.assert_fails != 0) begin
            $display("%0d assertion failures in the bound checker", DUT.u_assert.assert_fails);
            errors += DUT.u_assert.assert_fails;
        end
        $display("summary: %0d tests, %0d failed, %0d checks, %0d errors",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

// File: project.f
+incdir+.
rng_pkg.sv
rng_lfsr_core.sv
rng_fifo.sv
rng_wb_regs.sv
rng_top.sv
rng_assert.sv
tb_rng.sv

// File: Bender.yml
package:
  name: rng_periph

sources:
  - include_dirs:
      - .
    files:
      - rng_pkg.sv
      - rng_lfsr_core.sv
      - rng_fifo.sv
      - rng_wb_regs.sv
      - rng_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - rng_assert.sv
      - tb_rng.sv
